/* r5_pkg.sv */
package r5_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and word types
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN = 32;  // register width, fixed
  localparam int ALEN = 32;  // byte address width, both buses

  typedef logic [XLEN-1:0]   xlen_t;      // register and data word
  typedef logic [ALEN-1:0]   addr_t;      // byte address
  typedef logic [31:0]       inst_t;      // instruction word
  typedef logic [4:0]        reg_idx_t;   // x0 .. x31
  typedef logic [XLEN/8-1:0] byte_sel_t;  // one bit per data byte

  localparam addr_t RESET_PC = 32'h0000_0000;  // first fetch

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_OP     = 7'b011_0011;

  //////////////////////////////////////////////////////////////////////
  // control selects
  //////////////////////////////////////////////////////////////////////

  // encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  // funct3 of the branch, NONE sits on an unused code
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_NONE = 3'b010,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_op_e;

  typedef enum logic [1:0] {
    PC_INC,  // pc + 4
    PC_BRN,  // pc + imm if taken
    PC_JMP   // alu sum, bit 0 cleared
  } pc_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PCI,  // link address
    WB_NONE
  } wb_sel_e;

  typedef enum logic [1:0] {
    SZ_B,
    SZ_H,
    SZ_W
  } ls_size_e;

endpackage

/* r5_gpr.sv */
`timescale 1ns/1ps

module r5_gpr import r5_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     rs1_en,
  input  logic     rs2_en,
  input  logic     rd_en,
  input  reg_idx_t rs1_adr,
  input  reg_idx_t rs2_adr,
  input  reg_idx_t rd_adr,
  output xlen_t    rs1_dat,
  output xlen_t    rs2_dat,
  input  xlen_t    rd_dat
);

  xlen_t regs [32];  // entry 0 never written

  // single write port, x0 stays zero
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && (rd_adr != '0)) begin
      regs[rd_adr] <= rd_dat;
    end
  end

  // combinational reads, zero when idle or x0
  assign rs1_dat = (rs1_en && (rs1_adr != '0)) ? regs[rs1_adr] : '0;
  assign rs2_dat = (rs2_en && (rs2_adr != '0)) ? regs[rs2_adr] : '0;

endmodule

/* r5_alu.sv */
`timescale 1ns/1ps

module r5_alu import r5_pkg::*; (
  input  alu_op_e op,
  input  xlen_t   rs1,
  input  xlen_t   rs2,
  output xlen_t   rd,
  output xlen_t   sum
);

  logic [4:0] shamt;  // shift amount
  logic       lt;     // signed less than
  logic       ltu;    // unsigned less than

  // adder output regardless of op
  // load/store address and jump target come from here
  assign sum = rs1 + rs2;

  assign shamt = rs2[4:0];
  assign lt    = $signed(rs1) < $signed(rs2);
  assign ltu   = rs1 < rs2;

  always_comb begin
    case (op)
      ALU_ADD:  rd = sum;
      ALU_SUB:  rd = rs1 - rs2;
      ALU_SLL:  rd = rs1 << shamt;
      ALU_SLT:  rd = {31'd0, lt};
      ALU_SLTU: rd = {31'd0, ltu};
      ALU_XOR:  rd = rs1 ^ rs2;
      ALU_SRL:  rd = rs1 >> shamt;
      ALU_SRA:  rd = xlen_t'($signed(rs1) >>> shamt);  // arithmetic
      ALU_OR:   rd = rs1 | rs2;
      ALU_AND:  rd = rs1 & rs2;
      default:  rd = '0;
    endcase
  end

endmodule

/* r5_br.sv */
`timescale 1ns/1ps

module r5_br import r5_pkg::*; (
  input  br_op_e op,
  input  xlen_t  rs1,
  input  xlen_t  rs2,
  output logic   tkn
);

  logic eq;   // equal
  logic lt;   // signed less than
  logic ltu;  // unsigned less than

  assign eq  = rs1 == rs2;
  assign lt  = $signed(rs1) < $signed(rs2);
  assign ltu = rs1 < rs2;

  always_comb begin
    case (op)
      BR_BEQ:  tkn = eq;
      BR_BNE:  tkn = ~eq;
      BR_BLT:  tkn = lt;
      BR_BGE:  tkn = ~lt;
      BR_BLTU: tkn = ltu;
      BR_BGEU: tkn = ~ltu;
      default: tkn = 1'b0;  // not a branch
    endcase
  end

endmodule

/* r5_lsu.sv */
`timescale 1ns/1ps

module r5_lsu import r5_pkg::*; (
  input  ls_size_e  size,
  input  logic      sign,     // sign-extend load data
  input  addr_t     adr,      // full byte address
  input  xlen_t     wdata,    // store data, lane 0
  output byte_sel_t sel,
  output xlen_t     wdt,      // store data in its lanes
  input  xlen_t     rdt,      // bus read data
  output xlen_t     ld_data   // extended load result
);

  logic [1:0] ofs;      // byte offset in word
  logic [4:0] bit_ofs;  // same, in bits
  byte_sel_t  mask;     // select before shift
  xlen_t      wmask;    // data mask before shift
  xlen_t      rsh;      // read data moved to lane 0

  assign ofs     = adr[1:0];
  assign bit_ofs = {ofs, 3'b000};

  // size masks
  always_comb begin
    case (size)
      SZ_B: begin
        mask  = 4'b0001;
        wmask = 32'h0000_00ff;
      end
      SZ_H: begin
        mask  = 4'b0011;
        wmask = 32'h0000_ffff;
      end
      SZ_W: begin
        mask  = 4'b1111;
        wmask = 32'hffff_ffff;
      end
      default: begin
        mask  = 4'b1111;
        wmask = 32'hffff_ffff;
      end
    endcase
  end

  assign sel = mask << ofs;
  assign wdt = (wdata & wmask) << bit_ofs;  // store lanes

  // load path, shift down then extend
  assign rsh = rdt >> bit_ofs;

  always_comb begin
    case (size)
      SZ_B:    ld_data = {{24{sign & rsh[7]}}, rsh[7:0]};
      SZ_H:    ld_data = {{16{sign & rsh[15]}}, rsh[15:0]};
      default: ld_data = rsh;  // word
    endcase
  end

endmodule

/* r5_core.sv */
`timescale 1ns/1ps

module r5_core import r5_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // program bus
  output logic      if_req,
  output addr_t     if_adr,
  input  inst_t     if_rdt,
  input  logic      if_ack,
  // data bus
  output logic      ls_req,  // read or write request
  output logic      ls_wen,  // write enable
  output addr_t     ls_adr,  // word aligned
  output byte_sel_t ls_sel,
  output xlen_t     ls_wdt,
  input  xlen_t     ls_rdt,  // valid the cycle after ack
  input  logic      ls_ack
);

  // fetch and pc
  logic       if_run;  // running since reset
  logic       id_vld;  // if_rdt holds the current instruction
  addr_t      if_pc;
  addr_t      if_pci;  // pc + 4
  addr_t      if_pcb;  // branch target
  addr_t      if_pcn;  // next pc
  logic       stall;
  logic       retire;  // next fetch accepted this cycle
  // decode
  inst_t      id_op;
  logic [6:0] opc;
  logic [2:0] f3;
  logic       f7b5;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  xlen_t      imm;
  logic       rs1_en, rs2_en;
  reg_idx_t   rs1_adr, rs2_adr, rd_adr;
  logic       a1_pc;   // operand 1 from pc
  logic       a2_imm;  // operand 2 from immediate
  alu_op_e    alu_op;
  br_op_e     br_op;
  pc_sel_e    pc_sel;
  wb_sel_e    wb_sel;
  logic       ls_en;
  ls_size_e   ls_size;
  logic       ls_sign;
  // execute
  xlen_t      gpr_rs1, gpr_rs2, gpr_rd;
  logic       gpr_we;
  xlen_t      alu_rs1, alu_rs2, alu_rd, alu_sum;
  logic       br_tkn;
  xlen_t      ld_data;
  logic       ls_fin;  // transfer done for this instruction
  logic       ls_dly;  // load data phase, one cycle

  //////////////////////////////////////////////////////////////////////
  // fetch, stall and pc
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) if_run <= 1'b0;
    else     if_run <= 1'b1;
  end

  // no fetch while a load waits or a store is still unacked
  assign if_req = if_run & ~(ls_req & ~(ls_wen & ls_ack));
  assign if_adr = if_pcn;

  assign stall  = (if_req & ~if_ack)    // fetch waiting
                | (ls_req & ~ls_ack)    // data transfer waiting
                | (ls_req & ~ls_wen);   // load, data comes next cycle
  assign retire = id_vld & ~stall;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) id_vld <= 1'b0;
    else     id_vld <= (if_req & if_ack) | (id_vld & stall);
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst)         if_pc <= RESET_PC;
    else if (retire) if_pc <= if_pcn;
  end

  assign if_pci = if_pc + 32'd4;
  assign if_pcb = if_pc + imm;  // imm is imm_b on branches

  always_comb begin
    if (!id_vld) begin
      if_pcn = if_pc;  // first fetch
    end else begin
      case (pc_sel)
        PC_INC:  if_pcn = if_pci;
        PC_BRN:  if_pcn = br_tkn ? if_pcb : if_pci;
        PC_JMP:  if_pcn = {alu_sum[31:1], 1'b0};
        default: if_pcn = if_pci;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  assign id_op   = if_rdt;  // memory holds it until next fetch
  assign opc     = id_op[6:0];
  assign f3      = id_op[14:12];
  assign f7b5    = id_op[30];
  assign rs1_adr = id_op[19:15];
  assign rs2_adr = id_op[24:20];
  assign rd_adr  = id_op[11:7];

  assign imm_i = {{20{id_op[31]}}, id_op[31:20]};
  assign imm_s = {{20{id_op[31]}}, id_op[31:25], id_op[11:7]};
  assign imm_b = {{19{id_op[31]}}, id_op[31], id_op[7], id_op[30:25], id_op[11:8], 1'b0};
  assign imm_u = {id_op[31:12], 12'h000};
  assign imm_j = {{11{id_op[31]}}, id_op[31], id_op[19:12], id_op[20], id_op[30:21], 1'b0};

  always_comb begin
    rs1_en  = 1'b0;
    rs2_en  = 1'b0;
    a1_pc   = 1'b0;
    a2_imm  = 1'b1;
    imm     = imm_i;
    alu_op  = ALU_ADD;
    br_op   = BR_NONE;
    pc_sel  = PC_INC;
    wb_sel  = WB_NONE;
    ls_en   = 1'b0;
    ls_wen  = 1'b0;
    ls_sign = ~f3[2];  // LBU, LHU clear it
    case (f3[1:0])
      2'b00:   ls_size = SZ_B;
      2'b01:   ls_size = SZ_H;
      default: ls_size = SZ_W;
    endcase
    case (opc)
      OPC_LUI: begin  // x0 read gives 0 + imm
        imm    = imm_u;
        wb_sel = WB_ALU;
      end
      OPC_AUIPC: begin
        a1_pc  = 1'b1;
        imm    = imm_u;
        wb_sel = WB_ALU;
      end
      OPC_JAL: begin
        a1_pc  = 1'b1;
        imm    = imm_j;
        pc_sel = PC_JMP;
        wb_sel = WB_PCI;
      end
      OPC_JALR: begin
        rs1_en = 1'b1;
        pc_sel = PC_JMP;
        wb_sel = WB_PCI;
      end
      OPC_BRANCH: begin  // alu and comparator see rs1, rs2
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        a2_imm = 1'b0;
        imm    = imm_b;
        br_op  = br_op_e'(f3);
        pc_sel = PC_BRN;
      end
      OPC_LOAD: begin
        rs1_en = 1'b1;
        ls_en  = 1'b1;
        wb_sel = WB_MEM;
      end
      OPC_STORE: begin
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        imm    = imm_s;
        ls_en  = 1'b1;
        ls_wen = 1'b1;
      end
      OPC_OP_IMM: begin  // funct7 only matters for SRAI
        rs1_en = 1'b1;
        alu_op = alu_op_e'({(f3 == 3'b101) & f7b5, f3});
        wb_sel = WB_ALU;
      end
      OPC_OP: begin
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        a2_imm = 1'b0;
        alu_op = alu_op_e'({f7b5, f3});
        wb_sel = WB_ALU;
      end
      default: ;  // unsupported, retires as a nop
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // execute and load/store
  //////////////////////////////////////////////////////////////////////

  r5_gpr gpr (
    .clk     (clk),
    .rst     (rst),
    .rs1_en  (rs1_en),
    .rs2_en  (rs2_en),
    .rd_en   (gpr_we),
    .rs1_adr (rs1_adr),
    .rs2_adr (rs2_adr),
    .rd_adr  (rd_adr),
    .rs1_dat (gpr_rs1),
    .rs2_dat (gpr_rs2),
    .rd_dat  (gpr_rd)
  );

  assign alu_rs1 = a1_pc  ? if_pc : gpr_rs1;
  assign alu_rs2 = a2_imm ? imm   : gpr_rs2;

  r5_alu alu (
    .op  (alu_op),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  r5_br br (
    .op  (br_op),
    .rs1 (gpr_rs1),
    .rs2 (gpr_rs2),
    .tkn (br_tkn)
  );

  assign ls_req = id_vld & ls_en & ~ls_fin;  // once per instruction
  assign ls_adr = {alu_sum[31:2], 2'b00};

  r5_lsu lsu (
    .size    (ls_size),
    .sign    (ls_sign),
    .adr     (alu_sum),
    .wdata   (gpr_rs2),
    .sel     (ls_sel),
    .wdt     (ls_wdt),
    .rdt     (ls_rdt),
    .ld_data (ld_data)
  );

  // blocks a second request while the fetch still waits
  always_ff @(posedge clk, posedge rst) begin
    if (rst)                  ls_fin <= 1'b0;
    else if (retire)          ls_fin <= 1'b0;
    else if (ls_req & ls_ack) ls_fin <= 1'b1;
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) ls_dly <= 1'b0;
    else     ls_dly <= ls_req & ls_ack & ~ls_wen;
  end

  //////////////////////////////////////////////////////////////////////
  // write back
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (wb_sel)
      WB_ALU:  gpr_rd = alu_rd;
      WB_MEM:  gpr_rd = ld_data;
      WB_PCI:  gpr_rd = if_pci;  // link
      WB_NONE: gpr_rd = '0;
      default: gpr_rd = '0;
    endcase
  end

  // loads write in their data phase, the rest only when retiring
  assign gpr_we = (wb_sel == WB_MEM) ? ls_dly : (retire & (wb_sel != WB_NONE));

endmodule

/* r5_assertions.sv */
`timescale 1ns/1ps

module r5_assertions import r5_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      if_req,
  input logic      ls_req,
  input logic      ls_wen,
  input addr_t     ls_adr,
  input byte_sel_t ls_sel,
  input xlen_t     ls_wdt,
  input logic      ls_ack
);

  // a load never shares a cycle with a fetch request
  a_no_load_with_fetch: assert property (@(posedge clk) disable iff (rst)
    !(if_req && ls_req && !ls_wen)) else $error("load request issued together with fetch");

  a_sel_nonzero: assert property (@(posedge clk) disable iff (rst)
    ls_req |-> (ls_sel != '0)) else $error("byte select empty on data request");

  // held request keeps its fields
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (ls_req && !ls_ack) |=> (ls_req && $stable(ls_adr) && $stable(ls_sel)
                             && $stable(ls_wen) && $stable(ls_wdt)))
    else $error("data request changed while waiting for ack");

  a_first_cycle_idle: assert property (@(posedge clk)
    $fell(rst) |-> !if_req) else $error("fetch request in first cycle after reset");

endmodule

bind r5_core r5_assertions u_assertions (
  .clk    (clk),
  .rst    (rst),
  .if_req (if_req),
  .ls_req (ls_req),
  .ls_wen (ls_wen),
  .ls_adr (ls_adr),
  .ls_sel (ls_sel),
  .ls_wdt (ls_wdt),
  .ls_ack (ls_ack)
);

/* r5_checker.sv */
`timescale 1ns/1ps

module r5_checker import r5_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      if_req,
  input  addr_t     if_adr,
  input  logic      if_ack,
  input  logic      ls_req,
  input  logic      ls_wen,
  input  addr_t     ls_adr,
  input  byte_sel_t ls_sel,
  input  xlen_t     ls_wdt,
  input  logic      ls_ack,
  input  inst_t     prog [256],       // program image
  input  xlen_t     dmem_init [256],  // data memory at reset
  input  addr_t     end_pc,           // self-jump address
  output logic      done,
  output int        errors,
  output int        fetches,
  output int        stores
);

  xlen_t     xr [32];   // model registers
  xlen_t     mem [256]; // model data memory
  addr_t     exp_pc;
  logic      st_pend;   // store expected from current instruction
  addr_t     st_adr;
  byte_sel_t st_sel;
  xlen_t     st_dat;
  logic      ld_pend;   // load expected from current instruction
  addr_t     ld_adr;
  int        end_hits;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic xlen_t alu_ref(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs one instruction on the model state and gives next pc and any access
  function automatic void ref_step(input inst_t ins, input addr_t pc, output addr_t npc,
                                   output logic st, output addr_t sa,
                                   output byte_sel_t ss, output xlen_t sd,
                                   output logic ld, output addr_t la);
    xlen_t    a;
    xlen_t    b;
    xlen_t    v;
    xlen_t    w;
    xlen_t    immi;
    xlen_t    imms;
    xlen_t    immb;
    xlen_t    immj;
    logic     tk;
    reg_idx_t rd;
    logic [2:0] f3;
    rd   = ins[11:7];
    f3   = ins[14:12];
    a    = xr[ins[19:15]];
    b    = xr[ins[24:20]];
    immi = {{20{ins[31]}}, ins[31:20]};
    imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    npc  = pc + 32'd4;
    st   = 1'b0;
    sa   = '0;
    ss   = '0;
    sd   = '0;
    ld   = 1'b0;
    la   = '0;
    v    = '0;
    case (ins[6:0])
      OPC_LUI:    v = {ins[31:12], 12'h000};
      OPC_AUIPC:  v = pc + {ins[31:12], 12'h000};
      OPC_JAL: begin
        v   = pc + 32'd4;
        npc = pc + immj;
      end
      OPC_JALR: begin
        npc = (a + immi) & ~32'd1;  // target before link write
        v   = pc + 32'd4;
      end
      OPC_BRANCH: begin
        case (f3)
          3'd0:    tk = (a == b);
          3'd1:    tk = (a != b);
          3'd4:    tk = ($signed(a) < $signed(b));
          3'd5:    tk = ($signed(a) >= $signed(b));
          3'd6:    tk = (a < b);
          default: tk = (a >= b);
        endcase
        if (tk) npc = pc + immb;
      end
      OPC_LOAD: begin
        w  = a + immi;
        ld = 1'b1;
        la = {w[31:2], 2'b00};
        v  = mem[w[9:2]] >> {w[1:0], 3'b000};
        case (f3)
          3'd0:    v = {{24{v[7]}}, v[7:0]};
          3'd1:    v = {{16{v[15]}}, v[15:0]};
          3'd4:    v = {24'd0, v[7:0]};
          3'd5:    v = {16'd0, v[15:0]};
          default: ;
        endcase
      end
      OPC_STORE: begin
        w  = a + imms;
        st = 1'b1;
        sa = {w[31:2], 2'b00};
        case (f3)
          3'd0: begin
            ss = 4'b0001 << w[1:0];
            sd = {24'd0, b[7:0]} << {w[1:0], 3'b000};
          end
          3'd1: begin
            ss = 4'b0011 << w[1:0];
            sd = {16'd0, b[15:0]} << {w[1:0], 3'b000};
          end
          default: begin
            ss = 4'b1111;
            sd = b;
          end
        endcase
        for (int i = 0; i < 4; i++) begin
          if (ss[i]) mem[w[9:2]][8*i +: 8] = sd[8*i +: 8];
        end
      end
      OPC_OP_IMM: v = alu_ref(f3, (f3 == 3'd5) & ins[30], a, immi);
      OPC_OP:     v = alu_ref(f3, ins[30], a, b);
      default: ;
    endcase
    // model register write skips x0
    if (rd != '0 && ins[6:0] != OPC_BRANCH && ins[6:0] != OPC_STORE) xr[rd] = v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare bus traffic against the model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] = dmem_init[i];
      end
      for (int i = 0; i < 32; i++) begin
        xr[i] = '0;
      end
      exp_pc   = RESET_PC;
      st_pend  = 1'b0;
      ld_pend  = 1'b0;
      end_hits = 0;
      done     = 1'b0;
      errors   = 0;
      fetches  = 0;
      stores   = 0;
    end else begin
      // a load completes before the next fetch
      if (ls_req && ls_ack && !ls_wen) begin
        if (!ld_pend) begin
          $display("unexpected load from %h, current instruction is no load", ls_adr);
          errors++;
        end else if (ls_adr !== ld_adr) begin
          $display("[FAIL] ls_adr: got %h expected %h", ls_adr, ld_adr);
          errors++;
        end
        ld_pend = 1'b0;
      end
      // a store completes before the next fetch
      if (ls_req && ls_ack && ls_wen) begin
        stores++;
        if (!st_pend) begin
          $display("unexpected store to %h, current instruction is no store", ls_adr);
          errors++;
        end else begin
          if (ls_adr !== st_adr) begin
            $display("[FAIL] ls_adr: got %h expected %h", ls_adr, st_adr);
            errors++;
          end
          if (ls_sel !== st_sel) begin
            $display("[FAIL] ls_sel: got %h expected %h", ls_sel, st_sel);
            errors++;
          end
          if (ls_wdt !== st_dat) begin
            $display("[FAIL] ls_wdt: got %h expected %h", ls_wdt, st_dat);
            errors++;
          end
        end
        st_pend = 1'b0;
      end
      if (if_req && if_ack) begin
        fetches++;
        if (st_pend) begin
          $display("store expected at %h never happened before next fetch", st_adr);
          errors++;
          st_pend = 1'b0;
        end
        if (ld_pend) begin
          $display("load expected at %h never happened before next fetch", ld_adr);
          errors++;
          ld_pend = 1'b0;
        end
        if (if_adr !== exp_pc) begin
          $display("[FAIL] if_adr: got %h expected %h", if_adr, exp_pc);
          errors++;
        end
        if (exp_pc == end_pc) end_hits++;
        ref_step(prog[exp_pc[9:2]], exp_pc, exp_pc, st_pend, st_adr, st_sel, st_dat,
                 ld_pend, ld_adr);
        done = (end_hits >= 3);
      end
    end
  end

endmodule

/* r5_tb.sv */
`timescale 1ns/1ps

module r5_tb import r5_pkg::*; ();

  localparam int NUM_INST     = 200;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_INST * 8) * CLK_PERIOD + 2000;
  localparam addr_t END_PC    = addr_t'(NUM_INST * 4);

  logic      clk = 1'b0;
  logic      rst;
  logic      if_req;
  logic      if_ack;
  addr_t     if_adr;
  inst_t     if_rdt;
  logic      ls_req;
  logic      ls_wen;
  logic      ls_ack;
  addr_t     ls_adr;
  byte_sel_t ls_sel;
  xlen_t     ls_wdt;
  xlen_t     ls_rdt;
  inst_t     prog [256];
  xlen_t     dmem [256];
  logic      done;
  int        errors;
  int        fetches;
  int        stores;
  int unsigned seed_val;

  always #(CLK_PERIOD / 2) clk = ~clk;

  r5_core i_dut (.*);

  r5_checker u_chk (
    .clk (clk), .rst (rst), .if_req (if_req), .if_adr (if_adr), .if_ack (if_ack),
    .ls_req (ls_req), .ls_wen (ls_wen), .ls_adr (ls_adr), .ls_sel (ls_sel),
    .ls_wdt (ls_wdt), .ls_ack (ls_ack), .prog (prog), .dmem_init (dmem),
    .end_pc (END_PC), .done (done), .errors (errors), .fetches (fetches), .stores (stores)
  );

  //////////////////////////////////////////////////////////////////////
  // instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_s(logic [11:0] imm, reg_idx_t rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], OPC_STORE};  // base x0
  endfunction

  function automatic inst_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // random program with forward control flow only and a final self-jump
  task automatic build_program();
    int         kind;
    int         k;
    logic [2:0] f3;
    logic [11:0] imm;
    for (int i = 0; i < 256; i++) begin
      prog[i] = enc_j(21'd0, 5'd0);
    end
    for (int i = 0; i < NUM_INST; i++) begin
      kind = int'($urandom % 16);
      k    = 1 + int'($urandom % 4);
      if (i + k > NUM_INST) k = NUM_INST - i;  // stay inside the program
      f3   = 3'($urandom);
      if (kind < 5) begin
        prog[i] = enc_r({1'b0, (f3 == 3'd0 || f3 == 3'd5) & 1'($urandom), 5'd0},
                        5'($urandom), 5'($urandom), f3, 5'($urandom), OPC_OP);
      end else if (kind < 8) begin
        imm = 12'($urandom);
        if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
        if (f3 == 3'd5) imm = {1'b0, imm[10], 5'd0, imm[4:0]};  // srli or srai
        prog[i] = enc_i(imm, 5'($urandom), f3, 5'($urandom), OPC_OP_IMM);
      end else if (kind < 10) begin
        prog[i] = {20'($urandom), 5'($urandom), (kind == 8) ? OPC_LUI : OPC_AUIPC};
      end else if (kind < 12) begin
        case ($urandom % 5)
          0: begin
            f3  = 3'd2;
            imm = 12'(($urandom % 256) * 4);
          end
          1: begin
            f3  = 3'd1;
            imm = 12'(($urandom % 512) * 2);
          end
          2: begin
            f3  = 3'd5;
            imm = 12'(($urandom % 512) * 2);
          end
          3: begin
            f3  = 3'd0;
            imm = 12'($urandom % 1024);
          end
          default: begin
            f3  = 3'd4;
            imm = 12'($urandom % 1024);
          end
        endcase
        prog[i] = enc_i(imm, 5'd0, f3, 5'($urandom), OPC_LOAD);
      end else if (kind < 14) begin
        case ($urandom % 3)
          0: begin
            f3  = 3'd2;
            imm = 12'(($urandom % 256) * 4);
          end
          1: begin
            f3  = 3'd1;
            imm = 12'(($urandom % 512) * 2);
          end
          default: begin
            f3  = 3'd0;
            imm = 12'($urandom % 1024);
          end
        endcase
        prog[i] = enc_s(imm, 5'($urandom), f3);
      end else if (kind == 14) begin
        if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
        prog[i] = enc_b(13'(k * 4), 5'($urandom % 8), 5'($urandom % 8), f3);
      end else if ($urandom % 2 == 0) begin
        prog[i] = enc_j(21'(k * 4), 5'($urandom));
      end else begin
        prog[i] = enc_i(12'((i + k) * 4), 5'd0, 3'd0, 5'($urandom), OPC_JALR);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus models drive their outputs 1 ns after the edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : bus_models
    logic  live;  // out of reset at this edge
    logic  f_go;
    logic  d_go;
    logic  d_wen;
    addr_t f_adr;
    addr_t d_adr;
    byte_sel_t d_sel;
    xlen_t d_wdt;
    live  = !rst;
    f_go  = if_req && if_ack;
    d_go  = ls_req && ls_ack;
    d_wen = ls_wen;
    f_adr = if_adr;
    d_adr = ls_adr;
    d_sel = ls_sel;
    d_wdt = ls_wdt;
    #1;
    if (live) begin
      if (f_go) if_rdt = prog[f_adr[9:2]];
      if (d_go && d_wen) begin
        for (int i = 0; i < 4; i++) begin
          if (d_sel[i]) dmem[d_adr[9:2]][8*i +: 8] = d_wdt[8*i +: 8];
        end
      end else if (d_go) begin
        ls_rdt = dmem[d_adr[9:2]];
      end
      if_ack = ($urandom % 4) != 0;  // about a quarter withheld
      ls_ack = ($urandom % 4) != 0;
    end
  end

  initial begin
    rst      = 1'b1;
    if_rdt   = '0;
    if_ack   = 1'b0;
    ls_rdt   = '0;
    ls_ack   = 1'b0;
    seed_val = $urandom(32'h2a19_c771);
    for (int i = 0; i < 256; i++) begin
      dmem[i] = {8'(i) ^ 8'hc3, 8'(i * 7), ~8'(i), 8'(i) ^ 8'h5a};
    end
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
    wait (done);
    @(posedge clk);
    $display("errors: %0d, fetches checked: %0d, stores checked: %0d",
             errors, fetches, stores);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: program did not reach its final self-jump in %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* compile.f */
r5_pkg.sv
r5_gpr.sv
r5_alu.sv
r5_br.sv
r5_lsu.sv
r5_core.sv
r5_assertions.sv
r5_checker.sv
r5_tb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = r5_tb
FLIST = compile.f
LOG   = sim.log
BIN   = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

$(BIN): $(shell cat $(FLIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
